// File: verilog.f
hdl/bgPkg.sv
hdl/bgConfig.sv
hdl/bgLoader.sv
hdl/frameBuffer.sv
hdl/bgLoadTop.sv
verification/sramModel.sv
verification/bgLoadTb.sv

// File: run.sh
#!/bin/sh
# build and run the background loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module bgLoadTb \
	-f verilog.f --Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "compile step failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// File: verification/bgLoadTb.sv
module bgLoadTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned ImageWords = 4 * bgPkg::BgStride;
	// worst case per word is about 7 cycles
	localparam int unsigned DoneTimeout = 2000;
	localparam int unsigned BusyTimeout = 20;
	localparam int unsigned IdleCycles = 12;

	typedef logic [bgPkg::WordWidth-1:0] wordT;
	typedef wordT imageT [ImageWords];
	typedef wordT fbT [bgPkg::FbWords];

	logic Clk;
	logic rstN;
	bgPkg::cfgWriteT cfgWrite;
	logic loadStart;
	bgPkg::sramReqT sramReq;
	bgPkg::sramRespT sramResp;
	logic [bgPkg::FbAddrWidth-1:0] fbRdAddr;
	wordT fbRdData;
	logic busy;
	bgPkg::loadStatusT status;

	// sram contents as the test sees them
	imageT image;
	// expected frame buffer, starts unknown like the block ram
	fbT fbModel;

	int mismatches;
	int protocolErrors;
	int timeouts;

	bgLoadTop dut_i (
		.Clk(Clk),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.loadStart(loadStart),
		.sramReq(sramReq),
		.sramResp(sramResp),
		.fbRdAddr(fbRdAddr),
		.fbRdData(fbRdData),
		.busy(busy),
		.status(status)
	);

	sramModel sram_i (
		.Clk(Clk),
		.req(sramReq),
		.resp(sramResp)
	);

	initial
	begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// expected result of one load
	// words up to FbWords are copied until one lies above the marker threshold
	// the word after a full buffer must be a marker, otherwise truncated
	function automatic void refLoad(
		input imageT img,
		input bgPkg::bgSelT sel,
		input fbT prevFb,
		output fbT expFb,
		output int expCount,
		output logic expTrunc
	);
		int base;
		int i;
		wordT w;
		logic stop;
		base = int'(sel) * int'(bgPkg::BgStride);
		expFb = prevFb;
		expCount = 0;
		expTrunc = 1'b0;
		stop = 1'b0;
		for (i = 0; i <= int'(bgPkg::FbWords) && !stop; i++)
		begin
			w = img[base + i];
			if (w > bgPkg::EndMarker)
				stop = 1'b1;
			else if (i == int'(bgPkg::FbWords))
			begin
				expTrunc = 1'b1;
				stop = 1'b1;
			end
			else
			begin
				expFb[i] = w;
				expCount = i + 1;
			end
		end
	endfunction

	task automatic checkStatus(input string name, input bgPkg::loadStatusT exp,
		input bgPkg::loadStatusT act);
		string expText;
		string actText;
		if (act !== exp)
		begin
			expText = $sformatf("done=%0b truncated=%0b wordCount=%0d",
				exp.done, exp.truncated, exp.wordCount);
			actText = $sformatf("done=%0b truncated=%0b wordCount=%0d",
				act.done, act.truncated, act.wordCount);
			$display("FAIL %s: expected %s actual %s", name, expText, actText);
			mismatches++;
		end
	endtask

	task automatic checkWord(input string name, input wordT exp, input wordT act);
		if (act !== exp)
		begin
			$display("FAIL %s: expected %h actual %h", name, exp, act);
			mismatches++;
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic driveEdge();
		@(posedge Clk);
		#1;
	endtask

	task automatic writeConfig(input bgPkg::bgSelT sel);
		driveEdge();
		cfgWrite.valid = 1'b1;
		cfgWrite.sel = sel;
		driveEdge();
		cfgWrite = '0;
	endtask

	task automatic pulseStart();
		driveEdge();
		loadStart = 1'b1;
		driveEdge();
		loadStart = 1'b0;
	endtask

	task automatic copyImage();
		for (int i = 0; i < int'(ImageWords); i++)
			sram_i.image[i] = image[i];
	endtask

	// random picture words, all at or below the threshold
	task automatic fillImage();
		for (int bg = 0; bg < 4; bg++)
		begin
			for (int w = 0; w < int'(bgPkg::BgWords); w++)
				image[bg * int'(bgPkg::BgStride) + w] = wordT'($urandom_range(32'hEFFF, 0));
			image[bg * int'(bgPkg::BgStride) + int'(bgPkg::BgWords)] = 16'hFFFF;
		end
		copyImage();
	endtask

	// loader must stay quiet, no request, no busy, no repeated done
	task automatic checkIdle(input string name, input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge Clk);
			if (busy || status.done || sramReq.valid)
			begin
				$display("%s: loader active while it should be idle", name);
				protocolErrors++;
			end
		end
	endtask

	task automatic waitBusy(input string name);
		int cycles;
		cycles = 0;
		while (!busy && cycles < int'(BusyTimeout))
		begin
			@(negedge Clk);
			cycles++;
		end
		if (!busy)
		begin
			$display("%s: busy never went high after the start strobe", name);
			timeouts++;
		end
	endtask

	task automatic waitDone(input string name, output bgPkg::loadStatusT st, output bit seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		st = '0;
		while (!seen && cycles < int'(DoneTimeout))
		begin
			@(negedge Clk);
			if (status.done)
			begin
				seen = 1'b1;
				st = status;
				if (busy)
				begin
					$display("%s: busy still high in the done cycle", name);
					protocolErrors++;
				end
			end
			cycles++;
		end
		if (!seen)
		begin
			$display("%s: load did not finish within %0d cycles", name, DoneTimeout);
			timeouts++;
		end
	endtask

	// registered read port, one cycle per address
	task automatic readFrame(output fbT got);
		for (int i = 0; i < int'(bgPkg::FbWords); i++)
		begin
			driveEdge();
			fbRdAddr = bgPkg::FbAddrWidth'(i);
			@(posedge Clk);
			@(negedge Clk);
			got[i] = fbRdData;
		end
	endtask

	// compare process for one load already started
	task automatic finishLoad(input string name, input bgPkg::bgSelT sel);
		fbT expFb;
		fbT got;
		int expCount;
		logic expTrunc;
		bgPkg::loadStatusT st;
		bgPkg::loadStatusT expStatus;
		bit seen;
		refLoad(image, sel, fbModel, expFb, expCount, expTrunc);
		waitDone(name, st, seen);
		expStatus.done = 1'b1;
		expStatus.truncated = expTrunc;
		expStatus.wordCount = (bgPkg::FbAddrWidth + 1)'(expCount);
		if (seen)
			checkStatus(name, expStatus, st);
		// a stray second load would show up here
		checkIdle(name, IdleCycles);
		// truncated and wordCount stay put after the done pulse
		if (seen)
		begin
			expStatus.done = 1'b0;
			checkStatus($sformatf("%s hold", name), expStatus, status);
		end
		readFrame(got);
		for (int i = 0; i < int'(bgPkg::FbWords); i++)
			checkWord($sformatf("%s word %0d", name, i), expFb[i], got[i]);
		fbModel = expFb;
	endtask

	initial
	begin
		void'($urandom(32'h1423));
		mismatches = 0;
		protocolErrors = 0;
		timeouts = 0;
		rstN = 1'b0;
		cfgWrite = '0;
		loadStart = 1'b0;
		fbRdAddr = '0;
		fillImage();

		repeat (10) @(posedge Clk);
		#1;
		rstN = 1'b1;

		// quiet after reset until the first start
		@(negedge Clk);
		checkStatus("reset", '0, status);
		checkIdle("reset", 20);

		// full copy of each background
		for (int n = 0; n < 4; n++)
		begin
			writeConfig(bgPkg::bgSelT'(n));
			pulseStart();
			finishLoad($sformatf("fullLoad%0d", n), bgPkg::bgSelT'(n));
		end

		// F000 is data, F001 ends the load at offset 10
		image[int'(bgPkg::BgStride) + 5] = 16'hF000;
		image[int'(bgPkg::BgStride) + 10] = 16'hF001;
		copyImage();
		writeConfig(bgPkg::BgOne);
		pulseStart();
		finishLoad("earlyMarker", bgPkg::BgOne);

		// marker as the very first word leaves the buffer untouched
		image[0] = 16'hFFFF;
		copyImage();
		writeConfig(bgPkg::BgZero);
		pulseStart();
		finishLoad("markerFirst", bgPkg::BgZero);

		// marker of background two overwritten with picture data
		image[2 * int'(bgPkg::BgStride) + int'(bgPkg::BgWords)] = 16'h0123;
		copyImage();
		writeConfig(bgPkg::BgTwo);
		pulseStart();
		finishLoad("missingMarker", bgPkg::BgTwo);

		// start and config strobes in the middle of a load
		writeConfig(bgPkg::BgThree);
		pulseStart();
		waitBusy("busyStrobes");
		repeat (5) driveEdge();
		// new selection first, so a restart would copy from background one
		cfgWrite.valid = 1'b1;
		cfgWrite.sel = bgPkg::BgOne;
		driveEdge();
		cfgWrite = '0;
		if (!busy)
		begin
			$display("busyStrobes: load ended before the extra strobes were sent");
			protocolErrors++;
		end
		loadStart = 1'b1;
		driveEdge();
		loadStart = 1'b0;
		finishLoad("ignoredStart", bgPkg::BgThree);

		// the selection written during the load applies now
		pulseStart();
		finishLoad("deferredConfig", bgPkg::BgOne);

		$display("errors: %0d mismatches, %0d protocol, %0d timeouts",
			mismatches, protocolErrors, timeouts);
		if (mismatches == 0 && protocolErrors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verification/sramModel.sv
module sramModel (
	input logic Clk,
	input bgPkg::sramReqT req,
	output bgPkg::sramRespT resp
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned ImageWords = 4 * bgPkg::BgStride;

	// four backgrounds back to back, each closed by a marker word
	// filled by the testbench before each load
	logic [bgPkg::WordWidth-1:0] image [ImageWords];

	// reads past the image look like a marker
	function automatic logic [bgPkg::WordWidth-1:0] readWord(
		input logic [bgPkg::SramAddrWidth-1:0] addr
	);
		if (int'(addr) < int'(ImageWords))
			return image[int'(addr)];
		return '1;
	endfunction

	// one request at a time, answered after 1 to 4 cycles
	initial
	begin
		int unsigned delay;
		logic [bgPkg::SramAddrWidth-1:0] addr;
		resp = '0;
		forever
		begin
			// request is a registered pulse, stable at the falling edge
			@(negedge Clk);
			if (req.valid)
			begin
				addr = req.addr;
				delay = $urandom_range(4, 1);
				repeat (delay) @(posedge Clk);
				#1;
				resp.valid = 1'b1;
				resp.data = readWord(addr);
				// response valid for exactly one cycle
				@(posedge Clk);
				#1;
				resp = '0;
			end
		end
	end

endmodule

// File: hdl/bgLoadTop.sv
module bgLoadTop (
	input logic Clk,
	input logic rstN,
	input bgPkg::cfgWriteT cfgWrite,
	input logic loadStart,
	output bgPkg::sramReqT sramReq,
	input bgPkg::sramRespT sramResp,
	input logic [bgPkg::FbAddrWidth-1:0] fbRdAddr,
	output logic [bgPkg::WordWidth-1:0] fbRdData,
	output logic busy,
	output bgPkg::loadStatusT status
);

	// start of the selected background in sram
	logic [bgPkg::SramAddrWidth-1:0] baseAddr;

	// loader to frame buffer write port
	bgPkg::fbWriteT fbWrite;

	// selection register and base address
	bgConfig config_i (
		.Clk(Clk),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.baseAddr(baseAddr)
	);

	// copy engine, sram in and frame buffer out
	bgLoader loader_i (
		.Clk(Clk),
		.rstN(rstN),
		.loadStart(loadStart),
		.baseAddr(baseAddr),
		.sramReq(sramReq),
		.sramResp(sramResp),
		.fbWrite(fbWrite),
		.busy(busy),
		.status(status)
	);

	// on-chip storage
	// read port goes straight to the top for checking
	frameBuffer fb_i (
		.Clk(Clk),
		.fbWrite(fbWrite),
		.fbRdAddr(fbRdAddr),
		.fbRdData(fbRdData)
	);

endmodule

// File: hdl/frameBuffer.sv
module frameBuffer (
	input logic Clk,
	input bgPkg::fbWriteT fbWrite,
	input logic [bgPkg::FbAddrWidth-1:0] fbRdAddr,
	output logic [bgPkg::WordWidth-1:0] fbRdData
);

	// word storage, same layout as a block ram
	logic [bgPkg::WordWidth-1:0] mem [bgPkg::FbWords];

	// address range checks
	logic wrInRange;
	logic rdInRange;

	// only the low bits index the array
	logic [bgPkg::FbIndexWidth-1:0] wrIndex;
	logic [bgPkg::FbIndexWidth-1:0] rdIndex;

	assign wrInRange = fbWrite.addr < bgPkg::FbAddrWidth'(bgPkg::FbWords);
	assign rdInRange = fbRdAddr < bgPkg::FbAddrWidth'(bgPkg::FbWords);

	assign wrIndex = fbWrite.addr[bgPkg::FbIndexWidth-1:0];
	assign rdIndex = fbRdAddr[bgPkg::FbIndexWidth-1:0];

	// write port
	// writes past the end are dropped
	always_ff @(posedge Clk)
	begin
		if (fbWrite.valid && wrInRange)
		begin
			mem[wrIndex] <= fbWrite.data;
		end
	end

	// registered read, data appears one cycle after the address
	// out of range reads return zero
	always_ff @(posedge Clk)
	begin
		if (rdInRange)
		begin
			fbRdData <= mem[rdIndex];
		end
		else
		begin
			fbRdData <= '0;
		end
	end

endmodule

// File: hdl/bgLoader.sv
module bgLoader (
	input logic Clk,
	input logic rstN,
	input logic loadStart,
	input logic [bgPkg::SramAddrWidth-1:0] baseAddr,
	output bgPkg::sramReqT sramReq,
	input bgPkg::sramRespT sramResp,
	output bgPkg::fbWriteT fbWrite,
	output logic busy,
	output bgPkg::loadStatusT status
);

	bgPkg::loaderStateT state;
	bgPkg::loaderStateT nextState;

	// address of the next sram word to read
	logic [bgPkg::SramAddrWidth-1:0] sramAddr;
	// address of the next frame buffer word to write
	logic [bgPkg::FbAddrWidth-1:0] fbAddr;
	// word held between response and write
	logic [bgPkg::WordWidth-1:0] wordReg;
	// words written so far in this load
	logic [bgPkg::FbAddrWidth:0] wordCount;
	logic truncated;
	logic donePulse;

	// response classification
	logic isMarker;
	logic atLimit;

	// F000 itself is image data, only larger values end the load
	assign isMarker = sramResp.data > bgPkg::EndMarker;

	// frame buffer already full, nothing more may be written
	assign atLimit = wordCount == (bgPkg::FbAddrWidth + 1)'(bgPkg::FbWords);

	// next state
	// once the buffer is full one more word is read
	// a marker there means the background was complete
	// anything else means the marker is missing and the load is truncated
	always_comb
	begin
		nextState = state;
		unique case (state)
			bgPkg::Idle:
			begin
				// start strobes only count while idle
				if (loadStart)
				begin
					nextState = bgPkg::Request;
				end
			end
			bgPkg::Request:
			begin
				nextState = bgPkg::WaitData;
			end
			bgPkg::WaitData:
			begin
				// latency of the sram varies, just wait for valid
				if (sramResp.valid)
				begin
					if (isMarker || atLimit)
					begin
						nextState = bgPkg::Idle;
					end
					else
					begin
						nextState = bgPkg::Write;
					end
				end
			end
			bgPkg::Write:
			begin
				nextState = bgPkg::Request;
			end
			default:
			begin
				nextState = bgPkg::Idle;
			end
		endcase
	end

	// state, addresses and status
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			state <= bgPkg::Idle;
			sramAddr <= '0;
			fbAddr <= '0;
			wordCount <= '0;
			truncated <= 1'b0;
			donePulse <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// done is a single-cycle pulse
			donePulse <= 1'b0;
			unique case (state)
				bgPkg::Idle:
				begin
					if (loadStart)
					begin
						// base is captured here, later config writes wait for the next load
						sramAddr <= baseAddr;
						fbAddr <= '0;
						wordCount <= '0;
						truncated <= 1'b0;
					end
				end
				bgPkg::WaitData:
				begin
					if (sramResp.valid)
					begin
						if (isMarker)
						begin
							donePulse <= 1'b1;
						end
						else if (atLimit)
						begin
							// no marker where one should be
							donePulse <= 1'b1;
							truncated <= 1'b1;
						end
					end
				end
				bgPkg::Write:
				begin
					// both sides step one word per write
					sramAddr <= sramAddr + 1'b1;
					fbAddr <= fbAddr + 1'b1;
					wordCount <= wordCount + 1'b1;
				end
				default:
				begin
				end
			endcase
		end
	end

	// response payload, captured for the write cycle
	always_ff @(posedge Clk)
	begin
		if (state == bgPkg::WaitData && sramResp.valid)
		begin
			wordReg <= sramResp.data;
		end
	end

	// one request pulse per Request cycle
	assign sramReq.valid = state == bgPkg::Request;
	assign sramReq.addr = sramAddr;

	// write happens in the cycle after the response
	assign fbWrite.valid = state == bgPkg::Write;
	assign fbWrite.addr = fbAddr;
	assign fbWrite.data = wordReg;

	// busy drops together with the done pulse
	assign busy = state != bgPkg::Idle;

	assign status.done = donePulse;
	assign status.truncated = truncated;
	assign status.wordCount = wordCount;

endmodule

// File: hdl/bgConfig.sv
module bgConfig (
	input logic Clk,
	input logic rstN,
	input bgPkg::cfgWriteT cfgWrite,
	output logic [bgPkg::SramAddrWidth-1:0] baseAddr
);

	// currently selected background
	bgPkg::bgSelT sel;

	// selection register, loaded only on a write strobe
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			sel <= bgPkg::BgZero;
		end
		else if (cfgWrite.valid)
		begin
			sel <= cfgWrite.sel;
		end
	end

	// base address follows the register, so it changes one cycle
	// after the strobe
	// backgrounds are packed back to back, each with its end word
	always_comb
	begin
		unique case (sel)
			bgPkg::BgZero:
			begin
				baseAddr = '0;
			end
			bgPkg::BgOne:
			begin
				baseAddr = bgPkg::SramAddrWidth'(bgPkg::BgStride);
			end
			bgPkg::BgTwo:
			begin
				baseAddr = bgPkg::SramAddrWidth'(2 * bgPkg::BgStride);
			end
			default:
			begin
				baseAddr = bgPkg::SramAddrWidth'(3 * bgPkg::BgStride);
			end
		endcase
	end

endmodule

// File: hdl/bgPkg.sv
package bgPkg;

	// sram side: 20-bit word address, 16-bit data
	localparam int unsigned SramAddrWidth = 20;
	// frame buffer addresses are word addresses too
	localparam int unsigned FbAddrWidth = 19;
	localparam int unsigned WordWidth = 16;

	// sizes kept small for simulation
	localparam int unsigned BgWords = 64;
	// each background is followed by a single marker word
	localparam int unsigned BgStride = BgWords + 1;
	// frame buffer holds exactly one background
	localparam int unsigned FbWords = BgWords;
	// bits that actually index the frame buffer array
	localparam int unsigned FbIndexWidth = $clog2(FbWords);

	// only a word strictly above this ends a load
	localparam logic [WordWidth-1:0] EndMarker = 16'hF000;

	typedef enum logic [1:0] {
		BgZero,
		BgOne,
		BgTwo,
		BgThree
	} bgSelT;

	typedef enum logic [2:0] {
		Idle,
		Request,
		WaitData,
		Write
	} loaderStateT;

	// selection write strobe from outside
	typedef struct packed {
		logic valid;
		bgSelT sel;
	} cfgWriteT;

	// one read request per word
	typedef struct packed {
		logic valid;
		logic [SramAddrWidth-1:0] addr;
	} sramReqT;

	typedef struct packed {
		logic valid;
		logic [WordWidth-1:0] data;
	} sramRespT;

	typedef struct packed {
		logic valid;
		logic [FbAddrWidth-1:0] addr;
		logic [WordWidth-1:0] data;
	} fbWriteT;

	// done pulses, truncated and wordCount hold until the next start
	typedef struct packed {
		logic done;
		logic truncated;
		logic [FbAddrWidth:0] wordCount;
	} loadStatusT;

endpackage
